//--- mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// word width in bits, a multiple of 8
`define MEM_DATA_W 32

// number of words held by the memory
`define MEM_ELS 256

// one strobe bit per byte lane
`define MEM_STRB_W (`MEM_DATA_W / 8)

// word index width
`define MEM_ADDR_W $clog2(`MEM_ELS)

// slack cycles on top of the expected test length
`define MEM_TO_MARGIN 1000

`endif

//--- mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

  // widths with a meaning of their own
  typedef logic [31:0]              axil_addr_t;
  typedef logic [`MEM_DATA_W-1:0]   data_t;
  typedef logic [`MEM_STRB_W-1:0]   strb_t;
  typedef logic [`MEM_ADDR_W-1:0]   word_addr_t;
  typedef logic [1:0]               axil_resp_t;

  localparam axil_resp_t OKAY = 2'b00;

  // axi4-lite channel payloads
  typedef struct packed {
    axil_addr_t addr;
    logic [2:0] prot;
  } axil_aw_t;

  typedef struct packed {
    axil_addr_t addr;
    logic [2:0] prot;
  } axil_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_t resp;
  } axil_b_t;

  typedef struct packed {
    data_t      data;
    axil_resp_t resp;
  } axil_r_t;

  // ram ports, the ram never stalls so there is no ready
  typedef struct packed {
    logic       valid;
    strb_t      mask;
    word_addr_t addr;
    data_t      data;
  } mem_wr_t;

  typedef struct packed {
    logic       valid;
    word_addr_t addr;
  } mem_rd_t;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  // byte address to word index, the low two bits and the top bits drop out
  function automatic word_addr_t to_word_addr(axil_addr_t byte_addr);
    return byte_addr[`MEM_ADDR_W+1:2];
  endfunction

endpackage

//--- mem_1r1w_sync.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_1r1w_sync (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                w_v_i,
  input  mem_pkg::word_addr_t w_addr_i,
  input  logic [7:0]          w_data_i,

  input  logic                r_v_i,
  input  mem_pkg::word_addr_t r_addr_i,
  output logic [7:0]          r_data_o
);

  logic [7:0] ram_q [`MEM_ELS];
  logic [7:0] r_data_q;

  // storage array
  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
    begin
      ram_q[w_addr_i] <= w_data_i;
    end
  end

  // read register only updates on a read, so it keeps the last value read
  // a same-edge write is not seen here (read-first)
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      r_data_q <= '0;
    end
    else if (r_v_i)
    begin
      r_data_q <= ram_q[r_addr_i];
    end
  end

  assign r_data_o = r_data_q;

endmodule

//--- mem_1r1w_sync_mask_write_byte.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_1r1w_sync_mask_write_byte (
  input  logic             clk_i,
  input  logic             rst_n_i,

  input  mem_pkg::mem_wr_t wr_i,
  input  mem_pkg::mem_rd_t rd_i,
  output mem_pkg::data_t   r_data_o
);

  import mem_pkg::*;

  strb_t bank_we;

  // one write enable per byte lane
  assign bank_we = {`MEM_STRB_W{wr_i.valid}} & wr_i.mask;

  for (genvar i = 0; i < `MEM_STRB_W; i++)
  begin : g_bank
    mem_1r1w_sync u_bank (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_v_i    (bank_we[i]),
      .w_addr_i (wr_i.addr),
      .w_data_i (wr_i.data[i*8 +: 8]),
      .r_v_i    (rd_i.valid),
      .r_addr_i (rd_i.addr),
      .r_data_o (r_data_o[i*8 +: 8])
    );
  end

  // an x in the mask would corrupt bank contents silently
  a_mask_known : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wr_i.valid |-> !$isunknown(wr_i.mask)
  )
  else
    $error("write mask has unknown bits");

  // read address must be clean whenever a read is issued
  a_rd_addr_known : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rd_i.valid |-> !$isunknown(rd_i.addr)
  )
  else
    $error("read address has unknown bits");

endmodule

//--- axil_write_ctrl.sv
`timescale 1ns/1ps

module axil_write_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // write address channel
  input  mem_pkg::axil_aw_t aw_i,
  input  logic              awvalid_i,
  output logic              awready_o,

  // write data channel
  input  mem_pkg::axil_w_t  w_i,
  input  logic              wvalid_i,
  output logic              wready_o,

  // write response channel
  output mem_pkg::axil_b_t  b_o,
  output logic              bvalid_o,
  input  logic              bready_i,

  // ram write port
  output mem_pkg::mem_wr_t  wr_o
);

  import mem_pkg::*;

  wr_state_e state_q;
  wr_state_e state_d;
  logic      aw_w_fire;

  // aw and w are only taken together, and only when no response is pending
  assign aw_w_fire = (state_q == WR_IDLE) && awvalid_i && wvalid_i;
  assign awready_o = aw_w_fire;
  assign wready_o  = aw_w_fire;

  // ram write lands on the same edge as the aw/w transfer
  always_comb
  begin
    wr_o.valid = aw_w_fire;
    wr_o.mask  = w_i.strb;
    wr_o.addr  = to_word_addr(aw_i.addr);
    wr_o.data  = w_i.data;
  end

  assign bvalid_o = (state_q == WR_RESP);
  assign b_o.resp = OKAY;

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      WR_IDLE:
      begin
        if (aw_w_fire)
        begin
          state_d = WR_RESP;
        end
      end
      WR_RESP:
      begin
        // held here until the master takes b
        if (bready_i)
        begin
          state_d = WR_IDLE;
        end
      end
      default:
      begin
        state_d = WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= WR_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  a_no_accept_in_resp : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (state_q == WR_RESP) |-> !(awready_o || wready_o)
  );

  a_bvalid_hold : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (bvalid_o && !bready_i) |=> bvalid_o
  );

endmodule

//--- axil_read_ctrl.sv
`timescale 1ns/1ps

module axil_read_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // read address channel
  input  mem_pkg::axil_ar_t ar_i,
  input  logic              arvalid_i,
  output logic              arready_o,

  // ram read port, data comes back one cycle after the request
  output mem_pkg::mem_rd_t  rd_o,
  input  mem_pkg::data_t    r_data_i,

  // read data channel
  output mem_pkg::axil_r_t  r_o,
  output logic              rvalid_o,
  input  logic              rready_i
);

  import mem_pkg::*;

  logic rvalid_q;
  logic ar_fire;

  // a new read may start when the r slot is empty or being drained
  assign arready_o = !rvalid_q || rready_i;
  assign ar_fire   = arvalid_i && arready_o;

  // no read while r is stalled, so the bank register keeps r data stable
  always_comb
  begin
    rd_o.valid = ar_fire;
    rd_o.addr  = to_word_addr(ar_i.addr);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rvalid_q <= 1'b0;
    end
    else if (arready_o)
    begin
      // refill on a new read, otherwise the slot empties
      rvalid_q <= arvalid_i;
    end
  end

  assign rvalid_o = rvalid_q;

  always_comb
  begin
    r_o.data = r_data_i;
    r_o.resp = OKAY;
  end

  // r payload comes from the ram register, one module away
  a_r_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (rvalid_o && !rready_i) |=> (rvalid_o && $stable(r_o))
  );

endmodule

//--- axil_byte_ram_top.sv
`timescale 1ns/1ps

module axil_byte_ram_top (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  mem_pkg::axil_aw_t aw_i,
  input  logic              awvalid_i,
  output logic              awready_o,

  input  mem_pkg::axil_w_t  w_i,
  input  logic              wvalid_i,
  output logic              wready_o,

  output mem_pkg::axil_b_t  b_o,
  output logic              bvalid_o,
  input  logic              bready_i,

  input  mem_pkg::axil_ar_t ar_i,
  input  logic              arvalid_i,
  output logic              arready_o,

  output mem_pkg::axil_r_t  r_o,
  output logic              rvalid_o,
  input  logic              rready_i
);

  import mem_pkg::*;

  mem_wr_t mem_wr;
  mem_rd_t mem_rd;
  data_t   mem_r_data;

  axil_write_ctrl u_wr (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .aw_i      (aw_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .w_i       (w_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .b_o       (b_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .wr_o      (mem_wr)
  );

  mem_1r1w_sync_mask_write_byte u_mem (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wr_i     (mem_wr),
    .rd_i     (mem_rd),
    .r_data_o (mem_r_data)
  );

  axil_read_ctrl u_rd (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ar_i      (ar_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rd_o      (mem_rd),
    .r_data_i  (mem_r_data),
    .r_o       (r_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i)
  );

endmodule

//--- tb_axil_byte_ram.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module tb_axil_byte_ram;

  import mem_pkg::*;

  // rough cost of one channel operation including stalls
  localparam int OP_CYC   = 12;
  localparam int TEST_CYC = 4 + (`MEM_ELS + 300) * OP_CYC;
  localparam int MAX_CYC  = 4 * TEST_CYC + `MEM_TO_MARGIN;

  logic        clk;
  logic        rst_n;
  axil_aw_t    aw;
  logic        awvalid;
  logic        awready;
  axil_w_t     w;
  logic        wvalid;
  logic        wready;
  axil_b_t     b;
  logic        bvalid;
  logic        bready;
  axil_ar_t    ar;
  logic        arvalid;
  logic        arready;
  axil_r_t     r;
  logic        rvalid;
  logic        rready;
  data_t       model [`MEM_ELS];
  logic [31:0] rng;
  int          cycles = 0;

  axil_byte_ram_top dut0 (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .aw_i      (aw),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .w_i       (w),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .b_o       (b),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .ar_i      (ar),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .r_o       (r),
    .rvalid_o  (rvalid),
    .rready_i  (rready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > MAX_CYC)
    begin
      report_failure($sformatf("timeout: tests still running after %0d cycles", MAX_CYC));
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
    begin
      report_failure($sformatf("[ERROR] %0t: %s, expected %h, got %h", $time, what, exp, got));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic draw(output logic [31:0] v);
    rng = xorshift32(rng);
    v = rng;
  endtask

  // word slot of a byte address, the memory wraps past its size
  function automatic int model_index(input axil_addr_t addr);
    return (addr >> 2) % `MEM_ELS;
  endfunction

  // lanes with a zero strobe keep their old byte
  function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t strb);
    data_t res;
    res = old;
    for (int i = 0; i < `MEM_STRB_W; i++)
    begin
      if (strb[i])
      begin
        res[i*8 +: 8] = nw[i*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic next_edge();
    @(posedge clk);
    #2;
  endtask

  task automatic axil_write(input axil_addr_t addr, input data_t data, input strb_t strb);
    logic done;
    aw = '{addr, 3'b000};
    w = '{data, strb};
    awvalid = 1'b1;
    wvalid = 1'b1;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = awready && wready;
      next_edge();
    end
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    model[model_index(addr)] = merge_bytes(model[model_index(addr)], data, strb);
    @(negedge clk);
    while (!bvalid)
    begin
      @(negedge clk);
    end
    check_eq(b.resp, OKAY, "write response");
    next_edge();
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, input data_t exp, input int stall);
    logic done;
    ar = '{addr, 3'b000};
    arvalid = 1'b1;
    rready = (stall == 0);
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = arready;
      next_edge();
    end
    // a second read waits on ar through the stall and must not touch r
    arvalid = (stall > 0);
    ar = '{addr + 32'd4, 3'b000};
    @(negedge clk);
    while (!rvalid)
    begin
      @(negedge clk);
    end
    for (int i = 0; i < stall; i++)
    begin
      check_eq(r.data, exp, "read data under back-pressure");
      check_eq(arready, 1'b0, "arready under back-pressure");
      next_edge();
      rready = (i == stall - 1);
      @(negedge clk);
      check_eq(rvalid, 1'b1, "rvalid under back-pressure");
    end
    check_eq(r.data, exp, "read data");
    check_eq(r.resp, OKAY, "read response");
    next_edge();
    if (stall > 0)
    begin
      // the waiting read is taken on the r transfer and comes out next
      arvalid = 1'b0;
      @(negedge clk);
      check_eq(rvalid, 1'b1, "rvalid of the read held behind the stall");
      check_eq(r.data, model[model_index(addr + 32'd4)], "read data after the stall");
      next_edge();
    end
    rready = 1'b0;
  endtask

  // reads on consecutive cycles, results must come back in issue order
  task automatic read_burst(input axil_addr_t base, input int n);
    data_t exp_q[$];
    int    issued;
    issued = 0;
    rready = 1'b1;
    while (issued < n || exp_q.size() > 0)
    begin
      arvalid = (issued < n);
      ar = '{base + issued * 4, 3'b000};
      @(negedge clk);
      if (rvalid && exp_q.size() == 0)
      begin
        report_failure("an R beat arrived with no read outstanding");
      end
      if (rvalid)
      begin
        check_eq(r.data, exp_q.pop_front(), "back-to-back read data");
      end
      if (arvalid && arready)
      begin
        exp_q.push_back(model[model_index(base + issued * 4)]);
        issued++;
      end
      next_edge();
    end
    arvalid = 1'b0;
    rready = 1'b0;
  endtask

  task automatic collide(input axil_addr_t addr, input data_t data);
    data_t old;
    old = model[model_index(addr)];
    aw = '{addr, 3'b000};
    w = '{data, '1};
    ar = '{addr, 3'b000};
    {awvalid, wvalid, arvalid, rready, bready} = 5'b11111;
    @(negedge clk);
    check_eq({awready, wready, arready}, 3'b111, "joint accept of write and read");
    next_edge();
    {awvalid, wvalid, arvalid} = 3'b000;
    model[model_index(addr)] = data;
    @(negedge clk);
    check_eq({bvalid, rvalid}, 2'b11, "responses after the collision");
    check_eq(r.data, old, "read-first data on collision");
    next_edge();
    {rready, bready} = 2'b00;
    axil_read(addr, data, 0);
  endtask

  initial
  begin
    data_t       d;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] mix;
    rst_n = 1'b0;
    {aw, w, ar} = '0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    rng = 32'hc77b;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq({awready, wready, bvalid, rvalid, arready}, 5'b00001, "state after reset");
    next_edge();
    // fill pattern mixes every address bit
    for (int i = 0; i < `MEM_ELS; i++)
    begin
      axil_write(i * 4, data_t'(i * 32'h9e3779b1 ^ (i << 11)), '1);
    end
    for (int i = 0; i < 8; i++)
    begin
      draw(d);
      axil_write(32'h40 + i * 28, d, '1);
      axil_read(32'h40 + i * 28, d, 0);
    end
    draw(d);
    axil_write(32'h300, d, '1);
    for (int i = 0; i < `MEM_STRB_W; i++)
    begin
      draw(d);
      axil_write(32'h300, d, strb_t'(1) << i);
      axil_read(32'h300, model[model_index(32'h300)], 0);
    end
    foreach (mix[i])
    begin
      if (i < 3)
      begin
        draw(d);
        axil_write(32'h300, d, strb_t'(i == 0 ? 'h5 : (i == 1 ? 'ha : 'h0)));
        axil_read(32'h300, model[model_index(32'h300)], 0);
      end
    end
    axil_read(32'h14, model[5], 1);
    axil_read(32'h88, model[34], 3);
    axil_read(32'h3fc, model[255], 6);
    read_burst(32'h100, 8);
    draw(d);
    collide(32'h1a0, d);
    for (int i = 0; i < 200; i++)
    begin
      draw(op);
      draw(a);
      draw(d);
      draw(mix);
      if (op[0])
      begin
        axil_write(a, d, mix[`MEM_STRB_W-1:0]);
      end
      else
      begin
        axil_read(a, model[model_index(a)], mix[11:8] % 5);
      end
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
mem_pkg.sv
mem_1r1w_sync.sv
mem_1r1w_sync_mask_write_byte.sv
axil_write_ctrl.sv
axil_read_ctrl.sv
axil_byte_ram_top.sv
tb_axil_byte_ram.sv

//--- Bender.yml
package:
  name: axil_byte_ram

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - mem_1r1w_sync.sv
      - mem_1r1w_sync_mask_write_byte.sv
      - axil_write_ctrl.sv
      - axil_read_ctrl.sv
      - axil_byte_ram_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_axil_byte_ram.sv
